/* s86_video_macros.svh */
`ifndef S86_VIDEO_MACROS_SVH
`define S86_VIDEO_MACROS_SVH

////////////////////////////////////////////////////////////
// screen geometry, shrunk for simulation
////////////////////////////////////////////////////////////

// pixel clocks per line, visible part first
`define S86_H_TOTAL       64
`define S86_H_ACTIVE      48
// lines per frame, visible part first
`define S86_V_TOTAL       40
`define S86_V_ACTIVE      32

// sync pulses sit in the blanked region
`define S86_HSYNC_START   52
`define S86_HSYNC_LEN     6
`define S86_VSYNC_START   34
`define S86_VSYNC_LEN     2

////////////////////////////////////////////////////////////
// layers and host port
////////////////////////////////////////////////////////////

`define S86_TILE_SIZE     8
`define S86_SPRITE_COUNT  4
`define S86_HOST_ADDR_W   10
`define S86_HOST_DATA_W   16

`endif

/* s86_video_pkg.sv */
`include "s86_video_macros.svh"

package s86_video_pkg;

	// beam position counters
	typedef logic [6:0] hpos_t;
	typedef logic [5:0] vpos_t;

	// colour index, palette in [7:4], pen in [3:0]
	// pen 0 is transparent
	typedef logic [7:0] dot_t;

	// one gun of the rgb output
	typedef logic [3:0] colour_t;

	// palette entry, red in [11:8], green [7:4], blue [3:0]
	typedef logic [11:0] rgb_t;

	// horizontal tile scroll
	typedef logic [6:0] scroll_t;

	// host write port
	typedef logic [`S86_HOST_ADDR_W-1:0] host_addr_t;
	typedef logic [`S86_HOST_DATA_W-1:0] host_data_t;

	// four-phase handshake states
	typedef enum logic [1:0] {IDLE, WRITE, ACK, WAIT_RELEASE} host_state_t;

endpackage

/* video_timing.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module video_timing (
	input  logic                 clk_6m,
	input  logic                 rst_n,
	output s86_video_pkg::hpos_t hpos,
	output s86_video_pkg::vpos_t vpos,
	output logic                 active,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 blank,
	output logic                 blank_d
);

	// limits at counter width
	localparam s86_video_pkg::hpos_t H_LAST = s86_video_pkg::hpos_t'(`S86_H_TOTAL - 1);
	localparam s86_video_pkg::vpos_t V_LAST = s86_video_pkg::vpos_t'(`S86_V_TOTAL - 1);
	localparam s86_video_pkg::hpos_t H_END = s86_video_pkg::hpos_t'(`S86_H_TOTAL);
	localparam s86_video_pkg::hpos_t H_ACT = s86_video_pkg::hpos_t'(`S86_H_ACTIVE);
	localparam s86_video_pkg::vpos_t V_ACT = s86_video_pkg::vpos_t'(`S86_V_ACTIVE);
	localparam s86_video_pkg::hpos_t HS_START = s86_video_pkg::hpos_t'(`S86_HSYNC_START);
	localparam s86_video_pkg::hpos_t HS_END =
		s86_video_pkg::hpos_t'(`S86_HSYNC_START + `S86_HSYNC_LEN);
	localparam s86_video_pkg::vpos_t VS_START = s86_video_pkg::vpos_t'(`S86_VSYNC_START);
	localparam s86_video_pkg::vpos_t VS_END =
		s86_video_pkg::vpos_t'(`S86_VSYNC_START + `S86_VSYNC_LEN);

	logic hsync_now;
	logic vsync_now;
	logic hsync_d;
	logic vsync_d;

	// line and frame counters, free running
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			hpos <= '0;
			vpos <= '0;
		end else if (hpos == H_LAST) begin
			hpos <= '0;
			vpos <= (vpos == V_LAST) ? '0 : s86_video_pkg::vpos_t'(vpos + 1);
		end else begin
			hpos <= s86_video_pkg::hpos_t'(hpos + 1);
		end
	end

	// visible window, straight to the generators
	assign active = (hpos < H_ACT) && (vpos < V_ACT);
	assign hsync_now = (hpos >= HS_START) && (hpos < HS_END);
	assign vsync_now = (vpos >= VS_START) && (vpos < VS_END);

	////////////////////////////////////////////////////////////
	// two-stage delay to line up with the colour pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			hsync_d <= 1'b0;
			vsync_d <= 1'b0;
			blank_d <= 1'b1;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
			blank   <= 1'b1;
		end else begin
			// stage 1, beside the layer dots
			hsync_d <= hsync_now;
			vsync_d <= vsync_now;
			blank_d <= !active;
			// stage 2, beside r g b
			hsync   <= hsync_d;
			vsync   <= vsync_d;
			blank   <= blank_d;
		end
	end

	// line counter stays inside the line
	a_hpos_range: assert property (@(posedge clk_6m) disable iff (!rst_n)
		hpos < H_END)
		else $error("hpos out of range: %0d", hpos);

endmodule

/* host_regs.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module host_regs (
	input  logic                                   clk_6m,
	input  logic                                   rst_n,
	input  logic                                   host_req,
	input  s86_video_pkg::host_addr_t              host_addr,
	input  s86_video_pkg::host_data_t              host_wdata,
	output logic                                   host_ack,
	output s86_video_pkg::scroll_t                 scroll_x,
	output s86_video_pkg::dot_t                    back_colour,
	output logic                                   spr_wr_en,
	output logic [$clog2(`S86_SPRITE_COUNT)-1:0]   spr_wr_index,
	output logic                                   spr_wr_word,
	output s86_video_pkg::host_data_t              spr_wr_data,
	output logic                                   pal_wr_en,
	output s86_video_pkg::dot_t                    pal_wr_addr,
	output s86_video_pkg::rgb_t                    pal_wr_data
);

	localparam int IDX_W = $clog2(`S86_SPRITE_COUNT);

	// address map
	localparam s86_video_pkg::host_addr_t SCROLL_ADDR = 'h000;
	localparam s86_video_pkg::host_addr_t BACK_ADDR = 'h001;
	localparam s86_video_pkg::host_addr_t SPR_BASE = 'h010;
	localparam s86_video_pkg::host_addr_t SPR_END =
		s86_video_pkg::host_addr_t'('h010 + 2 * `S86_SPRITE_COUNT);
	localparam s86_video_pkg::host_addr_t PAL_BASE = 'h100;
	localparam s86_video_pkg::host_addr_t PAL_END = 'h200;

	s86_video_pkg::host_state_t state;
	s86_video_pkg::host_state_t state_next;
	s86_video_pkg::host_addr_t  spr_offset;
	logic in_write;
	logic hit_spr;
	logic hit_pal;
	logic any_wr;

	////////////////////////////////////////////////////////////
	// four-phase handshake
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			s86_video_pkg::IDLE:         if (host_req) state_next = s86_video_pkg::WRITE;
			s86_video_pkg::WRITE:        state_next = s86_video_pkg::ACK;
			// host may already have let go
			s86_video_pkg::ACK:
				state_next = host_req ? s86_video_pkg::WAIT_RELEASE : s86_video_pkg::IDLE;
			s86_video_pkg::WAIT_RELEASE: if (!host_req) state_next = s86_video_pkg::IDLE;
			default:                     state_next = s86_video_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			state <= s86_video_pkg::IDLE;
		else
			state <= state_next;
	end

	assign in_write = (state == s86_video_pkg::WRITE);
	assign host_ack = (state == s86_video_pkg::ACK) || (state == s86_video_pkg::WAIT_RELEASE);

	// address decode, only acted on in WRITE
	assign hit_spr = (host_addr >= SPR_BASE) && (host_addr < SPR_END);
	assign hit_pal = (host_addr >= PAL_BASE) && (host_addr < PAL_END);
	assign spr_offset = host_addr - SPR_BASE;

	// scroll and back colour live here
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			scroll_x    <= '0;
			back_colour <= '0;
		end else if (in_write) begin
			if (host_addr == SCROLL_ADDR)
				scroll_x <= s86_video_pkg::scroll_t'(host_wdata);
			if (host_addr == BACK_ADDR)
				back_colour <= s86_video_pkg::dot_t'(host_wdata);
		end
	end

	// one-cycle strobes, sprite word 0 is position, word 1 palette and enable
	assign spr_wr_en    = in_write && hit_spr;
	assign spr_wr_index = spr_offset[IDX_W:1];
	assign spr_wr_word  = spr_offset[0];
	assign spr_wr_data  = host_wdata;
	assign pal_wr_en    = in_write && hit_pal;
	assign pal_wr_addr  = s86_video_pkg::dot_t'(host_addr);
	assign pal_wr_data  = s86_video_pkg::rgb_t'(host_wdata);

	assign any_wr = spr_wr_en || pal_wr_en;

	// ack only ever answers a request
	a_ack_needs_req: assert property (@(posedge clk_6m) disable iff (!rst_n)
		$rose(host_ack) |-> host_req)
		else $error("host_ack rose without host_req");

	// a strobe is followed by the ack, never by a second strobe
	a_one_strobe: assert property (@(posedge clk_6m) disable iff (!rst_n)
		any_wr |=> (host_ack && !any_wr))
		else $error("second write strobe in one handshake");

endmodule

/* tilegen.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module tilegen (
	input  logic                   clk_6m,
	input  logic                   rst_n,
	input  s86_video_pkg::hpos_t   hpos,
	input  s86_video_pkg::vpos_t   vpos,
	input  logic                   active,
	input  s86_video_pkg::scroll_t scroll_x,
	output s86_video_pkg::dot_t    tile_dot
);

	// bits of position inside one tile
	localparam int TILE_BITS = $clog2(`S86_TILE_SIZE);
	localparam s86_video_pkg::hpos_t PEN_MASK = s86_video_pkg::hpos_t'(`S86_TILE_SIZE - 1);

	s86_video_pkg::hpos_t   xs;
	s86_video_pkg::colour_t tile_col;
	s86_video_pkg::colour_t tile_row;
	s86_video_pkg::colour_t tile_pal;
	s86_video_pkg::colour_t tile_pen;

	////////////////////////////////////////////////////////////
	// scrolled tile map, patterned instead of rom
	////////////////////////////////////////////////////////////

	// scrolled column wraps at 128
	assign xs = s86_video_pkg::hpos_t'(hpos + scroll_x);

	// tile coordinates
	assign tile_col = s86_video_pkg::colour_t'(xs >> TILE_BITS);
	assign tile_row = s86_video_pkg::colour_t'(vpos >> TILE_BITS);

	// palette per tile, mod 16
	assign tile_pal = tile_col + tile_row;

	// pen pattern inside the tile
	// zero on the diagonal, so the back colour shows through
	assign tile_pen = s86_video_pkg::colour_t'((xs ^ s86_video_pkg::hpos_t'(vpos)) & PEN_MASK);

	// registered dot, one cycle after the counters
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			tile_dot <= '0;
		else if (active)
			tile_dot <= {tile_pal, tile_pen};
		else
			// transparent outside the window
			tile_dot <= '0;
	end

endmodule

/* spritegen.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module spritegen (
	input  logic                                 clk_6m,
	input  logic                                 rst_n,
	input  s86_video_pkg::hpos_t                 hpos,
	input  s86_video_pkg::vpos_t                 vpos,
	input  logic                                 active,
	input  logic                                 spr_wr_en,
	input  logic [$clog2(`S86_SPRITE_COUNT)-1:0] spr_wr_index,
	input  logic                                 spr_wr_word,
	input  s86_video_pkg::host_data_t            spr_wr_data,
	output s86_video_pkg::dot_t                  sprite_dot
);

	localparam int TILE_BITS = $clog2(`S86_TILE_SIZE);

	// attribute table
	s86_video_pkg::hpos_t   spr_x   [`S86_SPRITE_COUNT];
	s86_video_pkg::vpos_t   spr_y   [`S86_SPRITE_COUNT];
	s86_video_pkg::colour_t spr_pal [`S86_SPRITE_COUNT];
	logic [`S86_SPRITE_COUNT-1:0] spr_en;

	// per-sprite offsets, one spare bit catches a negative result
	logic [7:0] dx [`S86_SPRITE_COUNT];
	logic [6:0] dy [`S86_SPRITE_COUNT];
	logic [`S86_SPRITE_COUNT-1:0] hit;
	s86_video_pkg::dot_t dot_next;

	////////////////////////////////////////////////////////////
	// table writes from the host
	////////////////////////////////////////////////////////////

	// enables come up cleared
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			spr_en <= '0;
		else if (spr_wr_en && spr_wr_word)
			spr_en[spr_wr_index] <= spr_wr_data[4];
	end

	// word 0 position, word 1 palette
	always_ff @(posedge clk_6m) begin
		if (spr_wr_en) begin
			if (spr_wr_word) begin
				spr_pal[spr_wr_index] <= s86_video_pkg::colour_t'(spr_wr_data);
			end else begin
				spr_x[spr_wr_index] <= spr_wr_data[6:0];
				spr_y[spr_wr_index] <= spr_wr_data[13:8];
			end
		end
	end

	// box test, 8x8 from the top left corner
	for (genvar i = 0; i < `S86_SPRITE_COUNT; i++) begin : g_hit
		assign dx[i] = {1'b0, hpos} - {1'b0, spr_x[i]};
		assign dy[i] = {1'b0, vpos} - {1'b0, spr_y[i]};
		assign hit[i] = spr_en[i] && (dx[i][7:TILE_BITS] == '0) && (dy[i][6:TILE_BITS] == '0);
	end

	// lowest index wins, so walk down and let it overwrite
	always_comb begin
		dot_next = '0;
		for (int i = `S86_SPRITE_COUNT - 1; i >= 0; i--) begin
			if (hit[i])
				// pen 8..15, never transparent
				dot_next = {spr_pal[i],
					s86_video_pkg::colour_t'(`S86_TILE_SIZE + dx[i][TILE_BITS-1:0])};
		end
	end

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			sprite_dot <= '0;
		else
			sprite_dot <= active ? dot_next : '0;
	end

endmodule

/* dot_mixer_clut.sv */
`timescale 1ns/1ns

module dot_mixer_clut (
	input  logic                   clk_6m,
	input  logic                   rst_n,
	input  s86_video_pkg::dot_t    tile_dot,
	input  s86_video_pkg::dot_t    sprite_dot,
	input  s86_video_pkg::dot_t    back_colour,
	input  logic                   pal_wr_en,
	input  s86_video_pkg::dot_t    pal_wr_addr,
	input  s86_video_pkg::rgb_t    pal_wr_data,
	input  logic                   blank_d,
	output s86_video_pkg::colour_t r,
	output s86_video_pkg::colour_t g,
	output s86_video_pkg::colour_t b
);

	// colour lookup table, one entry per dot code
	s86_video_pkg::rgb_t pal_ram [256];

	s86_video_pkg::dot_t sel_dot;
	s86_video_pkg::rgb_t entry;

	////////////////////////////////////////////////////////////
	// layer priority
	////////////////////////////////////////////////////////////

	// sprite over tile over back colour
	always_comb begin
		if (sprite_dot[3:0] != '0)
			sel_dot = sprite_dot;
		else if (tile_dot[3:0] != '0)
			sel_dot = tile_dot;
		else
			sel_dot = back_colour;
	end

	////////////////////////////////////////////////////////////
	// palette ram
	////////////////////////////////////////////////////////////

	// host side write port
	always_ff @(posedge clk_6m) begin
		if (pal_wr_en)
			pal_ram[pal_wr_addr] <= pal_wr_data;
	end

	// read straight off the chosen index
	assign entry = pal_ram[sel_dot];

	// output register, dark while blanked
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			r <= '0;
			g <= '0;
			b <= '0;
		end else if (blank_d) begin
			r <= '0;
			g <= '0;
			b <= '0;
		end else begin
			r <= entry[11:8];
			g <= entry[7:4];
			b <= entry[3:0];
		end
	end

	// guns dark for every blanked pixel
	a_blank_dark: assert property (@(posedge clk_6m) disable iff (!rst_n)
		$past(blank_d) |-> (r == '0 && g == '0 && b == '0))
		else $error("colour during blank: %h %h %h", r, g, b);

endmodule

/* system86_video.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module system86_video (
	input  logic                      clk_6m,
	input  logic                      rst_n,
	input  logic                      host_req,
	input  s86_video_pkg::host_addr_t host_addr,
	input  s86_video_pkg::host_data_t host_wdata,
	output logic                      host_ack,
	output s86_video_pkg::colour_t    r,
	output s86_video_pkg::colour_t    g,
	output s86_video_pkg::colour_t    b,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      blank
);

	// beam position
	s86_video_pkg::hpos_t hpos;
	s86_video_pkg::vpos_t vpos;
	logic active;
	logic blank_d;

	// host register outputs
	s86_video_pkg::scroll_t scroll_x;
	s86_video_pkg::dot_t back_colour;
	logic spr_wr_en;
	logic [$clog2(`S86_SPRITE_COUNT)-1:0] spr_wr_index;
	logic spr_wr_word;
	s86_video_pkg::host_data_t spr_wr_data;
	logic pal_wr_en;
	s86_video_pkg::dot_t pal_wr_addr;
	s86_video_pkg::rgb_t pal_wr_data;

	// layer dots into the mixer
	s86_video_pkg::dot_t tile_dot;
	s86_video_pkg::dot_t sprite_dot;

	////////////////////////////////////////////////////////////
	// timing and host side
	////////////////////////////////////////////////////////////

	video_timing u_timing (.clk_6m, .rst_n, .hpos, .vpos, .active,
		.hsync, .vsync, .blank, .blank_d);

	host_regs u_host (.clk_6m, .rst_n, .host_req, .host_addr, .host_wdata, .host_ack,
		.scroll_x, .back_colour, .spr_wr_en, .spr_wr_index, .spr_wr_word,
		.spr_wr_data, .pal_wr_en, .pal_wr_addr, .pal_wr_data);

	////////////////////////////////////////////////////////////
	// layers side by side, then colour lookup
	////////////////////////////////////////////////////////////

	tilegen u_tile (.clk_6m, .rst_n, .hpos, .vpos, .active, .scroll_x, .tile_dot);

	spritegen u_sprite (.clk_6m, .rst_n, .hpos, .vpos, .active, .spr_wr_en,
		.spr_wr_index, .spr_wr_word, .spr_wr_data, .sprite_dot);

	dot_mixer_clut u_clut (.clk_6m, .rst_n, .tile_dot, .sprite_dot, .back_colour,
		.pal_wr_en, .pal_wr_addr, .pal_wr_data, .blank_d, .r, .g, .b);

endmodule

/* video_checker.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module video_checker (
	input  logic                      clk_6m,
	input  logic                      rst_n,
	input  logic                      host_req,
	input  s86_video_pkg::host_addr_t host_addr,
	input  s86_video_pkg::host_data_t host_wdata,
	input  logic                      host_ack,
	input  s86_video_pkg::colour_t    r,
	input  s86_video_pkg::colour_t    g,
	input  s86_video_pkg::colour_t    b,
	input  logic                      hsync,
	input  logic                      vsync,
	input  logic                      blank,
	output int                        errors,
	output int                        frames_checked
);

	localparam int TILE = `S86_TILE_SIZE;
	localparam int NSPR = `S86_SPRITE_COUNT;

	// shadow of what the host has written
	int scroll = 0;
	int back = 0;
	int spr_x [NSPR];
	int spr_y [NSPR];
	int spr_pal [NSPR];
	bit spr_en [NSPR];
	int pal [256];

	// beam tracking and handshake history
	int cycle = 0;
	int rst_cycles = 0;
	int px = 0;
	int line = 0;
	bit synced = 1'b0;
	bit dirty = 1'b1;
	int req_rise_at = 0;
	int req_fall_at = 0;
	logic req_prev = 1'b0;
	logic ack_prev = 1'b0;
	logic hsync_prev = 1'b0;
	logic vsync_prev = 1'b0;
	int err_count = 0;
	int clean_frames = 0;

	assign errors = err_count;
	assign frames_checked = clean_frames;

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("Fail %s expected %h actual %h", what, expected, actual);
		err_count++;
	endtask

	// address map of the host port
	task automatic apply_host_write(input int addr, input int data);
		int n;
		if (addr == 'h000)
			scroll = data % 128;
		else if (addr == 'h001)
			back = data % 256;
		else if (addr >= 'h010 && addr < 'h010 + 2 * NSPR) begin
			n = (addr - 'h010) / 2;
			if (addr % 2 == 0) begin
				spr_x[n] = data % 128;
				spr_y[n] = (data / 256) % 64;
			end else begin
				spr_pal[n] = data % 16;
				spr_en[n]  = ((data / 16) % 2) == 1;
			end
		end else if (addr >= 'h100 && addr < 'h200)
			pal[addr % 256] = data % 4096;
	endtask

	////////////////////////////////////////////////////////////
	// reference pixel
	////////////////////////////////////////////////////////////

	function automatic int expected_rgb(input int x, input int y);
		int xs;
		int dot;
		int n;
		bit found;
		// tile pattern on the scrolled column
		xs = (x + scroll) % 128;
		dot = ((xs / TILE + y / TILE) % 16) * 16 + ((xs ^ y) % 8);
		found = 1'b0;
		// first enabled box that covers the pixel
		for (n = 0; n < NSPR; n++) begin
			if (!found && spr_en[n] && x >= spr_x[n] && x < spr_x[n] + TILE &&
					y >= spr_y[n] && y < spr_y[n] + TILE) begin
				dot = spr_pal[n] * 16 + 8 + (x - spr_x[n]);
				found = 1'b1;
			end
		end
		// both layers clear
		if (!found && dot % 16 == 0)
			dot = back;
		return pal[dot];
	endfunction

	always @(posedge clk_6m) begin : sample
		int n;
		int want;
		logic [11:0] seen;
		seen = {r, g, b};
		cycle++;
		if (!rst_n) begin
			// first edge is where the reset lands
			if (rst_cycles > 0) begin
				if (host_ack)
					report_mismatch("host_ack in reset", 0, int'(host_ack));
				if (seen != '0)
					report_mismatch("rgb in reset", 0, int'(seen));
				if (!blank)
					report_mismatch("blank in reset", 1, int'(blank));
			end
			rst_cycles++;
			scroll = 0;
			back = 0;
			for (n = 0; n < NSPR; n++)
				spr_en[n] = 1'b0;
			synced = 1'b0;
			dirty = 1'b1;
			px = 0;
			line = 0;
		end else begin
			// handshake timing
			if (host_req && !req_prev)
				req_rise_at = cycle;
			if (!host_req && req_prev)
				req_fall_at = cycle;
			if (host_ack && !ack_prev) begin
				if (cycle - req_rise_at != 2)
					$display("host_ack rose %0d cycles after host_req, not 2",
						cycle - req_rise_at);
				if (cycle - req_rise_at != 2)
					err_count++;
				apply_host_write(int'(host_addr), int'(host_wdata));
			end
			if (!host_ack && ack_prev && cycle - req_fall_at != 1) begin
				$display("host_ack fell %0d cycles after host_req, not 1", cycle - req_fall_at);
				err_count++;
			end
			// ack may outlive req by the release cycle only
			if (host_ack && !host_req && !req_prev) begin
				$display("host_ack high while host_req is low");
				err_count++;
			end

			// host traffic spoils the frame for comparing
			if (host_req || host_ack)
				dirty = 1'b1;

			// frame boundary on vsync fall
			if (!vsync && vsync_prev) begin
				if (synced && line != `S86_V_ACTIVE) begin
					$display("frame had %0d visible lines instead of %0d", line,
						`S86_V_ACTIVE);
					err_count++;
				end
				if (synced && !dirty)
					clean_frames++;
				synced = 1'b1;
				dirty = host_req || host_ack;
				line = 0;
				px = 0;
			end

			// hsync closes a visible line
			if (hsync && !hsync_prev && px != 0) begin
				if (px != `S86_H_ACTIVE) begin
					$display("line %0d had %0d visible pixels instead of %0d", line, px,
						`S86_H_ACTIVE);
					err_count++;
				end
				line++;
				px = 0;
			end

			if (blank) begin
				if (seen != '0)
					report_mismatch("rgb during blank", 0, int'(seen));
			end else if (synced) begin
				if (!dirty) begin
					want = expected_rgb(px, line);
					if (int'(seen) != want)
						report_mismatch($sformatf("rgb at x=%0d y=%0d", px, line), want,
							int'(seen));
				end
				px++;
			end
		end
		req_prev = host_req;
		ack_prev = host_ack;
		hsync_prev = hsync;
		vsync_prev = vsync;
	end

endmodule

/* tb_system86_video.sv */
`timescale 1ns/1ns
`include "s86_video_macros.svh"

module tb_system86_video;

	// run length, about ten frames plus the palette load
	localparam int FRAME_CYCLES = `S86_H_TOTAL * `S86_V_TOTAL;
	localparam int HOST_WRITES = 300;
	localparam int MAX_CYCLES = 12 * FRAME_CYCLES + HOST_WRITES * 8 + 1000;
	// clean frames the stimulus below sets up
	localparam int MIN_FRAMES = 4;

	logic clk_6m = 1'b0;
	logic rst_n;
	logic host_req;
	s86_video_pkg::host_addr_t host_addr;
	s86_video_pkg::host_data_t host_wdata;
	logic host_ack;
	s86_video_pkg::colour_t r;
	s86_video_pkg::colour_t g;
	s86_video_pkg::colour_t b;
	logic hsync;
	logic vsync;
	logic blank;

	int cycles = 0;
	int errors;
	int frames_checked;
	int own_errors = 0;

	// 40 ns pixel clock
	always #20 clk_6m = ~clk_6m;

	system86_video UUT (.clk_6m, .rst_n, .host_req, .host_addr, .host_wdata, .host_ack,
		.r, .g, .b, .hsync, .vsync, .blank);

	video_checker u_checker (.clk_6m, .rst_n, .host_req, .host_addr, .host_wdata,
		.host_ack, .r, .g, .b, .hsync, .vsync, .blank, .errors, .frames_checked);

	// hard stop if the run hangs
	always @(posedge clk_6m) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////

	// four-phase write, address and data held while req is up
	task automatic host_write(input int addr, input int data);
		@(posedge clk_6m);
		host_addr  <= s86_video_pkg::host_addr_t'(addr);
		host_wdata <= s86_video_pkg::host_data_t'(data);
		host_req   <= 1'b1;
		do @(posedge clk_6m); while (!host_ack);
		host_req <= 1'b0;
		do @(posedge clk_6m); while (host_ack);
	endtask

	// skip to the next frame start, then let one whole frame pass
	task automatic run_clean_frame;
		@(negedge vsync);
		@(negedge vsync);
	endtask

	initial begin
		int i;
		int sx;
		int sy;
		void'($urandom(79501));
		rst_n      = 1'b0;
		host_req   = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		repeat (8) @(posedge clk_6m);
		rst_n <= 1'b1;

		// random palette, every entry
		for (i = 0; i < 256; i++)
			host_write('h100 + i, int'($urandom_range(0, 'hFFF)));
		host_write('h001, int'($urandom_range(0, 255)));
		host_write('h000, 0);
		// tiles alone, no scroll
		run_clean_frame();

		// tiles alone, scrolled
		host_write('h000, int'($urandom_range(1, 127)));
		run_clean_frame();

		// sprites 0 and 1 overlap, the rest land anywhere
		sx = int'($urandom_range(0, 40));
		sy = int'($urandom_range(0, 24));
		host_write('h010, sx + sy * 256);
		host_write('h012, (sx + 3) + (sy + 2) * 256);
		for (i = 2; i < `S86_SPRITE_COUNT; i++)
			host_write('h010 + 2 * i,
				int'($urandom_range(0, 44)) + int'($urandom_range(0, 28)) * 256);
		for (i = 0; i < `S86_SPRITE_COUNT; i++)
			host_write('h011 + 2 * i, int'($urandom_range(0, 15)) + 16);
		run_clean_frame();

		// live update, sprite 0 off and a new back colour
		host_write('h011, int'($urandom_range(0, 15)));
		host_write('h001, int'($urandom_range(0, 255)));
		run_clean_frame();
		repeat (4) @(posedge clk_6m);

		if (frames_checked < MIN_FRAMES) begin
			$display("only %0d frames were compared, %0d expected", frames_checked, MIN_FRAMES);
			own_errors++;
		end
		$display("errors: %0d in checker, %0d in testbench", errors, own_errors);
		if (errors + own_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
s86_video_pkg.sv
video_timing.sv
host_regs.sv
tilegen.sv
spritegen.sv
dot_mixer_clut.sv
system86_video.sv
video_checker.sv
tb_system86_video.sv

/* Makefile */
TOP = tb_system86_video

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
